// File: Bender.yml
package:
  name: acc_cpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/acc_cpu_pkg.sv
      - rtl/byte_bus_bridge.sv
      - rtl/acc_cpu_core.sv
      - rtl/acc_cpu_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - dv/acc_cpu_props.sv
      - dv/acc_cpu_tb.sv

// File: dv/acc_cpu_props.sv
// Bound checker for the accumulator processor pins
// Watches the shared pin enable and the fixed frame schedule of the bridge

`timescale 1ns/10ps

`include "acc_cpu_params.svh"

module acc_cpu_props (
  input logic                 clk,
  input logic                 reset,
  input logic                 step,
  input logic [`PIN_BITS-1:0] uio_oe
);

  localparam int PHASE_W = $clog2(`BUS_PHASES);

  logic [PHASE_W-1:0] phase_q;
  logic               reset_seen;

  // Nothing is checked before the first reset edge
  initial reset_seen = 1'b0;

  always @(posedge clk) begin
    if (reset) begin
      reset_seen <= 1'b1;
    end
  end

  // Own frame phase, same schedule as the bridge
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q <= '0;
    end else if (phase_q == PHASE_W'(`BUS_PHASES - 1)) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + PHASE_W'(1);
    end
  end

  a_oe_uniform: assert property (@(posedge clk)
    reset_seen |-> (uio_oe == '0 || uio_oe == '1))
    else $error("uio_oe is neither all zeros nor all ones");

  a_oe_reset: assert property (@(posedge clk)
    (reset_seen && reset) |-> (uio_oe == '0))
    else $error("uio_oe drives the shared pins during reset");

  // Enable settles in phase 1 and holds to the end of the frame
  a_oe_hold: assert property (@(posedge clk)
    (reset_seen && !reset && phase_q >= PHASE_W'(3)) |-> $stable(uio_oe))
    else $error("uio_oe changed inside a frame");

  a_step_frame: assert property (@(posedge clk)
    reset_seen |-> (step == (phase_q == '0 && !reset)))
    else $error("step pulse is off the frame schedule");

endmodule

bind acc_cpu_top acc_cpu_props props_i (
  .clk    (clk),
  .reset  (reset),
  .step   (step),
  .uio_oe (uio_oe)
);

// File: dv/acc_cpu_tb.sv
// Testbench for the pin-level accumulator processor
// Random program from an LFSR, memory served on the byte pins, and a
// frame-level instruction model that predicts every bus request

`timescale 1ns/10ps

`include "acc_cpu_params.svh"

module acc_cpu_tb;

  localparam int RESET_CYCLES = 16;
  localparam int FRAME_BUDGET = 400;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + `BUS_PHASES * FRAME_BUDGET + 50;
  localparam int MEM_WORDS    = 64;
  localparam int SHOW_FIRST   = 2;  // Pins show byte 0 in this phase
  localparam int SHOW_LAST    = 5;
  localparam int IN_FIRST     = 5;  // First phase that samples uio_in

  logic                 clk;
  logic                 reset;
  logic [`PIN_BITS-1:0] uo_out;
  logic [`PIN_BITS-1:0] uio_out;
  logic [`PIN_BITS-1:0] uio_oe;
  logic [`PIN_BITS-1:0] uio_in;

  logic [`WORD_BITS-1:0] pin_mem[MEM_WORDS];    // Memory seen on the pins
  logic [`WORD_BITS-1:0] model_mem[MEM_WORDS];  // Memory of the model
  logic [31:0]           rand_state;
  int                    cycle_count;
  int                    halt_frames;

  // Model state
  acc_cpu_pkg::core_state_e m_state;
  acc_cpu_pkg::bus_req_t    exp_req;
  logic [`WORD_BITS-1:0]    m_pc;
  logic [`WORD_BITS-1:0]    m_acc;
  logic [3:0]               m_op;

  acc_cpu_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_state[0]};  // One LFSR step per bit
      rand_state = lfsr_next(rand_state);
    end
  endtask

  function automatic acc_cpu_pkg::bus_req_t make_read(input logic [`WORD_BITS-1:0] addr);
    acc_cpu_pkg::bus_req_t r;
    r.addr  = addr;
    r.wdata = '0;
    r.rd    = 1'b1;
    return r;
  endfunction

  task automatic check_req(input acc_cpu_pkg::bus_req_t exp, input acc_cpu_pkg::bus_req_t got,
                           input int frame);
    if (got !== exp) begin
      $write("Mismatch at %0t: req in frame %0d expected addr=%h wdata=%h rd=%b",
             $time, frame, exp.addr, exp.wdata, exp.rd);
      $display(" got addr=%h wdata=%h rd=%b", got.addr, got.wdata, got.rd);
      stop_with_failure("Bus request differs from the model");
    end
  endtask

  task automatic check_pin_byte(input logic [`PIN_BITS-1:0] exp,
                                input logic [`PIN_BITS-1:0] got, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      stop_with_failure("Pin value is wrong");
    end
  endtask

  task automatic check_step(input logic exp, input logic got);
    if (got !== exp) begin
      $display("Mismatch at %0t: step expected %b got %b", $time, exp, got);
      stop_with_failure("Frame step pulse is off schedule");
    end
  endtask

  // Low words hold code and high words hold data
  task automatic fill_memory();
    logic [31:0] op;
    logic [31:0] opnd;
    logic [31:0] word;
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (a < 32) begin
        draw_bits(4, op);
        case (op[3:0])
          acc_cpu_pkg::OP_LDA, acc_cpu_pkg::OP_STA,
          acc_cpu_pkg::OP_ADD, acc_cpu_pkg::OP_SUB: begin
            draw_bits(5, opnd);
            opnd = opnd + 32'd32;  // Data area 32 to 63
          end
          acc_cpu_pkg::OP_JMP, acc_cpu_pkg::OP_JZ: begin
            draw_bits(5, opnd);    // Code area 0 to 31
          end
          default: begin
            draw_bits(28, opnd);
          end
        endcase
        word = {op[3:0], opnd[27:0]};
      end else begin
        draw_bits(32, word);
      end
      if (a == 31) begin
        word = {4'(acc_cpu_pkg::OP_HALT), 28'd0};
      end
      pin_mem[a]   = word;
      model_mem[a] = word;
    end
  endtask

  task automatic model_reset();
    m_state = acc_cpu_pkg::ST_FETCH;
    m_pc    = `RESET_PC;
    m_acc   = '0;
    m_op    = '0;
    exp_req = make_read(`RESET_PC);
  endtask

  // Close the predicted frame and work out the next request
  task automatic model_frame_done();
    logic [`WORD_BITS-1:0] data;
    logic [`WORD_BITS-1:0] opnd;
    data = '0;
    if (exp_req.rd) begin
      data = model_mem[exp_req.addr[5:0]];
    end else begin
      model_mem[exp_req.addr[5:0]] = exp_req.wdata;
    end
    case (m_state)
      acc_cpu_pkg::ST_FETCH: begin
        m_op = data[31:28];
        opnd = {4'd0, data[27:0]};
        case (m_op)
          acc_cpu_pkg::OP_LDA, acc_cpu_pkg::OP_ADD, acc_cpu_pkg::OP_SUB: begin
            m_state = acc_cpu_pkg::ST_EXEC;
            exp_req = make_read(opnd);
          end
          acc_cpu_pkg::OP_STA: begin
            m_state       = acc_cpu_pkg::ST_EXEC;
            exp_req.addr  = opnd;
            exp_req.wdata = m_acc;
            exp_req.rd    = 1'b0;
          end
          acc_cpu_pkg::OP_JMP: begin
            m_pc    = opnd;
            exp_req = make_read(m_pc);
          end
          acc_cpu_pkg::OP_JZ: begin
            m_pc    = (m_acc == '0) ? opnd : m_pc + 1;
            exp_req = make_read(m_pc);
          end
          acc_cpu_pkg::OP_LDI: begin
            m_acc   = opnd;
            m_pc    = m_pc + 1;
            exp_req = make_read(m_pc);
          end
          acc_cpu_pkg::OP_HALT: begin
            m_state = acc_cpu_pkg::ST_HALT;
            exp_req = make_read(m_pc);
          end
          default: begin
            m_pc    = m_pc + 1;  // No-op codes
            exp_req = make_read(m_pc);
          end
        endcase
      end
      acc_cpu_pkg::ST_EXEC: begin
        if (m_op == acc_cpu_pkg::OP_LDA) begin
          m_acc = data;
        end else if (m_op == acc_cpu_pkg::OP_ADD) begin
          m_acc = m_acc + data;
        end else if (m_op == acc_cpu_pkg::OP_SUB) begin
          m_acc = m_acc - data;
        end
        m_state = acc_cpu_pkg::ST_FETCH;
        m_pc    = m_pc + 1;
        exp_req = make_read(m_pc);
      end
      default: begin
        halt_frames++;
        exp_req = make_read(m_pc);
      end
    endcase
  endtask

  // Runs from the falling edge of phase 0 to phase 0 of the next frame
  task automatic run_frame(input int frame);
    acc_cpu_pkg::bus_req_t got;
    logic [`WORD_BITS-1:0] word;
    got  = '0;
    word = '0;
    for (int p = 1; p < `BUS_PHASES; p++) begin
      @(negedge clk);
      check_step(1'b0, dut_i.step);
      if (p >= SHOW_FIRST && p <= SHOW_LAST) begin
        got.addr[(p - SHOW_FIRST) * `PIN_BITS +: `PIN_BITS]  = uo_out;
        got.wdata[(p - SHOW_FIRST) * `PIN_BITS +: `PIN_BITS] = uio_out;
      end
      if (p == IN_FIRST) begin
        got.rd = (uio_oe == '0);
        check_pin_byte({`PIN_BITS{~exp_req.rd}}, uio_oe, "uio_oe");
        check_req(exp_req, got, frame);
        if (got.rd) begin
          word = pin_mem[got.addr[5:0]];
        end else begin
          pin_mem[got.addr[5:0]] = got.wdata;
        end
      end
      if (p >= IN_FIRST) begin
        uio_in = word[(p - IN_FIRST) * `PIN_BITS +: `PIN_BITS];  // LSB first
      end
    end
    @(negedge clk);
    check_step(1'b1, dut_i.step);
    uio_in = '0;
    model_frame_done();
  endtask

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
        stop_with_failure($sformatf("Timeout after %0d cycles", cycle_count));
      end
    end
  end

  initial begin
    reset       = 1'b1;
    uio_in      = '0;
    halt_frames = 0;
    rand_state  = 32'hadc;
    fill_memory();
    model_reset();

    repeat (RESET_CYCLES) @(negedge clk);
    check_pin_byte('0, uo_out, "uo_out");
    check_pin_byte('0, uio_out, "uio_out");
    check_pin_byte('0, uio_oe, "uio_oe");
    check_step(1'b0, dut_i.step);
    reset = 1'b0;  // This cycle is phase 0 of the first frame

    for (int f = 0; f < FRAME_BUDGET; f++) begin
      run_frame(f);
    end
    $display("Ran %0d frames, %0d of them after HALT", FRAME_BUDGET, halt_frames);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/acc_cpu_pkg.sv
rtl/byte_bus_bridge.sv
rtl/acc_cpu_core.sv
rtl/acc_cpu_top.sv
dv/acc_cpu_props.sv
dv/acc_cpu_tb.sv

// File: rtl/acc_cpu_core.sv
// Accumulator processor core
// Fetches and executes one bus frame at a time, advancing only on the
// bridge step pulse. Memory ops take a fetch and an execute frame

`timescale 1ns/10ps

`include "acc_cpu_params.svh"

module acc_cpu_core (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   step,
  input  logic [`WORD_BITS-1:0]  rdata,
  output acc_cpu_pkg::bus_req_t  req
);

  localparam int OP_BITS   = $bits(acc_cpu_pkg::opcode_e);
  localparam int OPND_BITS = `WORD_BITS - OP_BITS;

  acc_cpu_pkg::core_state_e state_q;
  acc_cpu_pkg::core_state_e state_d;
  acc_cpu_pkg::bus_req_t    req_q;
  acc_cpu_pkg::bus_req_t    req_d;
  acc_cpu_pkg::opcode_e     fetch_op;
  acc_cpu_pkg::opcode_e     exec_op;

  logic [`WORD_BITS-1:0] pc_q;
  logic [`WORD_BITS-1:0] pc_d;
  logic [`WORD_BITS-1:0] acc_q;
  logic [`WORD_BITS-1:0] acc_d;
  logic [`WORD_BITS-1:0] ir_q;
  logic [`WORD_BITS-1:0] ir_d;
  logic [`WORD_BITS-1:0] operand;
  logic [`WORD_BITS-1:0] pc_inc;
  logic [`WORD_BITS-1:0] jz_target;
  logic                  primed_q;

  // Read request for a word address, store data held at zero
  function automatic acc_cpu_pkg::bus_req_t read_req(input logic [`WORD_BITS-1:0] addr);
    acc_cpu_pkg::bus_req_t r;
    r.addr  = addr;
    r.wdata = '0;
    r.rd    = 1'b1;
    return r;
  endfunction

  // Decode of the fetched word and of the held instruction
  assign fetch_op  = acc_cpu_pkg::opcode_e'(rdata[`WORD_BITS-1 -: OP_BITS]);
  assign exec_op   = acc_cpu_pkg::opcode_e'(ir_q[`WORD_BITS-1 -: OP_BITS]);
  assign operand   = {{OP_BITS{1'b0}}, rdata[OPND_BITS-1:0]};  // Zero-extended
  assign pc_inc    = pc_q + `WORD_BITS'(1);
  assign jz_target = (acc_q == '0) ? operand : pc_inc;

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    acc_d   = acc_q;
    ir_d    = ir_q;
    req_d   = req_q;

    case (state_q)
      acc_cpu_pkg::ST_FETCH: begin
        ir_d = rdata;
        case (fetch_op)
          acc_cpu_pkg::OP_LDA,
          acc_cpu_pkg::OP_ADD,
          acc_cpu_pkg::OP_SUB: begin
            state_d = acc_cpu_pkg::ST_EXEC;  // Operand read next frame
            req_d   = read_req(operand);
          end
          acc_cpu_pkg::OP_STA: begin
            state_d     = acc_cpu_pkg::ST_EXEC;
            req_d.addr  = operand;
            req_d.wdata = acc_q;
            req_d.rd    = 1'b0;
          end
          acc_cpu_pkg::OP_JMP: begin
            pc_d  = operand;
            req_d = read_req(operand);
          end
          acc_cpu_pkg::OP_JZ: begin
            pc_d  = jz_target;
            req_d = read_req(jz_target);
          end
          acc_cpu_pkg::OP_LDI: begin
            acc_d = operand;
            pc_d  = pc_inc;
            req_d = read_req(pc_inc);
          end
          acc_cpu_pkg::OP_HALT: begin
            state_d = acc_cpu_pkg::ST_HALT;  // pc stays on the HALT
            req_d   = read_req(pc_q);
          end
          default: begin
            pc_d  = pc_inc;  // Codes 8 to 15
            req_d = read_req(pc_inc);
          end
        endcase
      end

      acc_cpu_pkg::ST_EXEC: begin
        case (exec_op)
          acc_cpu_pkg::OP_LDA: acc_d = rdata;
          acc_cpu_pkg::OP_ADD: acc_d = acc_q + rdata;  // Wraps at 32 bits
          acc_cpu_pkg::OP_SUB: acc_d = acc_q - rdata;
          default: acc_d = acc_q;                       // Store frame done
        endcase
        state_d = acc_cpu_pkg::ST_FETCH;
        pc_d    = pc_inc;
        req_d   = read_req(pc_inc);
      end

      default: begin
        // Halted, keep refetching the HALT address
        req_d = read_req(pc_q);
      end
    endcase
  end

  // The first step closes the reset-time frame, its data is not used
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= acc_cpu_pkg::ST_FETCH;
      pc_q     <= `RESET_PC;
      acc_q    <= '0;
      req_q    <= read_req(`RESET_PC);
      primed_q <= 1'b0;
    end else if (step) begin
      primed_q <= 1'b1;
      if (primed_q) begin
        state_q <= state_d;
        pc_q    <= pc_d;
        acc_q   <= acc_d;
        req_q   <= req_d;
      end
    end
  end

  // Instruction word kept for the execute frame
  always_ff @(posedge clk) begin
    if (step && primed_q) begin
      ir_q <= ir_d;
    end
  end

  assign req = req_q;

endmodule

// File: rtl/acc_cpu_params.svh
// Accumulator processor build constants
// Frame length of the pin bus, data and pin widths, and the reset PC

`ifndef ACC_CPU_PARAMS_SVH
`define ACC_CPU_PARAMS_SVH

// Clocks per memory frame: one step phase, four out phases, four in phases
`define BUS_PHASES 9

// Width of data words and word addresses
`define WORD_BITS 32

// Width of each pin byte
`define PIN_BITS 8

// Word address of the first instruction fetch
`define RESET_PC 32'd0

`endif

// File: rtl/acc_cpu_pkg.sv
// Accumulator processor shared types
// Bus request carried from the core to the pin bridge, opcodes and core states

`include "acc_cpu_params.svh"

package acc_cpu_pkg;

  // One memory access, held stable by the core for a whole frame
  typedef struct packed {
    logic [`WORD_BITS-1:0] addr;   // Word address
    logic [`WORD_BITS-1:0] wdata;  // Store data, zero on reads
    logic                  rd;     // 1 read frame, 0 write frame
  } bus_req_t;

  // Instruction opcode in bits 31:28, codes 8 to 15 act as no-op
  typedef enum logic [3:0] {
    OP_LDA  = 4'd0,  // acc = mem[opnd]
    OP_STA  = 4'd1,  // mem[opnd] = acc
    OP_ADD  = 4'd2,  // acc += mem[opnd]
    OP_SUB  = 4'd3,  // acc -= mem[opnd]
    OP_JMP  = 4'd4,  // pc = opnd
    OP_JZ   = 4'd5,  // pc = opnd when acc is zero
    OP_LDI  = 4'd6,  // acc = opnd
    OP_HALT = 4'd7   // Fetch own address forever
  } opcode_e;

  // Core sequencing state
  typedef enum logic [1:0] {
    ST_FETCH = 2'd0,  // Current frame fetches pc
    ST_EXEC  = 2'd1,  // Current frame accesses the operand
    ST_HALT  = 2'd2   // Stopped on a HALT
  } core_state_e;

endpackage

// File: rtl/acc_cpu_top.sv
// Pin-level top of the accumulator processor
// Joins the core to the byte-wide bus bridge, memory sits off chip

`timescale 1ns/10ps

`include "acc_cpu_params.svh"

module acc_cpu_top (
  input  logic                  clk,
  input  logic                  reset,
  output logic [`PIN_BITS-1:0]  uo_out,   // Address bytes
  output logic [`PIN_BITS-1:0]  uio_out,  // Store data bytes
  output logic [`PIN_BITS-1:0]  uio_oe,   // All ones in write frames
  input  logic [`PIN_BITS-1:0]  uio_in    // Read data bytes
);

  acc_cpu_pkg::bus_req_t req;    // Held for a whole frame
  logic                  step;   // One pulse per frame
  logic [`WORD_BITS-1:0] rdata;  // Word gathered in the last frame

  acc_cpu_core core_i (
    .clk   (clk),
    .reset (reset),
    .step  (step),
    .rdata (rdata),
    .req   (req)
  );

  byte_bus_bridge bridge_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .step    (step),
    .rdata   (rdata),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

endmodule

// File: rtl/byte_bus_bridge.sv
// Byte-wide pin bridge for the accumulator processor
// Cuts every memory access into a fixed frame: a step phase, four phases
// that drive address and store bytes out, and four that gather read bytes

`timescale 1ns/10ps

`include "acc_cpu_params.svh"

module byte_bus_bridge (
  input  logic                     clk,
  input  logic                     reset,
  input  acc_cpu_pkg::bus_req_t    req,
  output logic                     step,
  output logic [`WORD_BITS-1:0]    rdata,
  output logic [`PIN_BITS-1:0]     uo_out,
  output logic [`PIN_BITS-1:0]     uio_out,
  output logic [`PIN_BITS-1:0]     uio_oe,
  input  logic [`PIN_BITS-1:0]     uio_in
);

  localparam int PHASE_W   = $clog2(`BUS_PHASES);
  localparam int NUM_BYTES = `WORD_BITS / `PIN_BITS;
  localparam int BYTE_W    = $clog2(NUM_BYTES);

  // Phase map of one frame
  localparam logic [PHASE_W-1:0] STEP_PHASE  = PHASE_W'(0);
  localparam logic [PHASE_W-1:0] OUT_FIRST   = PHASE_W'(1);
  localparam logic [PHASE_W-1:0] OUT_LAST    = PHASE_W'(NUM_BYTES);
  localparam logic [PHASE_W-1:0] IN_FIRST    = PHASE_W'(NUM_BYTES + 1);
  localparam logic [PHASE_W-1:0] LAST_PHASE  = PHASE_W'(`BUS_PHASES - 1);

  logic [PHASE_W-1:0] phase_q;
  logic [PHASE_W-1:0] out_ofs;
  logic [PHASE_W-1:0] in_ofs;
  logic [BYTE_W-1:0]  out_idx;
  logic [BYTE_W-1:0]  in_idx;
  logic               out_phase;
  logic               in_phase;
  logic [`WORD_BITS-1:0] rdata_q;

  // Frame phase counter, first cycle out of reset is phase 0
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q <= STEP_PHASE;
    end else if (phase_q == LAST_PHASE) begin
      phase_q <= STEP_PHASE;
    end else begin
      phase_q <= phase_q + PHASE_W'(1);
    end
  end

  // No step while held in reset
  assign step = (phase_q == STEP_PHASE) && !reset;

  // Phase decode for the serializer and the gatherer
  assign out_phase = (phase_q >= OUT_FIRST) && (phase_q <= OUT_LAST);
  assign in_phase  = (phase_q >= IN_FIRST) && (phase_q <= LAST_PHASE);

  assign out_ofs = phase_q - OUT_FIRST;
  assign in_ofs  = phase_q - IN_FIRST;
  assign out_idx = out_ofs[BYTE_W-1:0];  // Byte 0 first, LSB first
  assign in_idx  = in_ofs[BYTE_W-1:0];

  // Address and store bytes, registered so the pins show byte k one phase later
  always_ff @(posedge clk) begin
    if (reset) begin
      uo_out  <= '0;
      uio_out <= '0;
    end else if (out_phase) begin
      uo_out  <= req.addr[out_idx*`PIN_BITS +: `PIN_BITS];
      uio_out <= req.wdata[out_idx*`PIN_BITS +: `PIN_BITS];
    end
  end

  // Read bytes arrive LSB first on the shared pins
  always_ff @(posedge clk) begin
    if (in_phase) begin
      rdata_q[in_idx*`PIN_BITS +: `PIN_BITS] <= uio_in;
    end
  end

  // Complete word is valid in phase 0 of the following frame
  assign rdata = rdata_q;

  // Shared pins drive only during a write frame
  assign uio_oe = {`PIN_BITS{~req.rd}};

endmodule
